//--- common/exu_pkg.sv
// ********************
// widths, typedefs and operation codes
// shared by the execute stage
// ********************
package exu_pkg;

    localparam int xlen = 64;
    localparam int ilen = 32;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [ilen-1:0] inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [2:0]      br_cond_t;

    // never forwarded, never hazards
    localparam reg_idx_t reg_zero = 5'd0;

    // ********************
    // alu operations
    // ********************
    localparam alu_op_t op_add  = 4'd0;
    localparam alu_op_t op_sub  = 4'd1;
    localparam alu_op_t op_and  = 4'd2;
    localparam alu_op_t op_or   = 4'd3;
    localparam alu_op_t op_xor  = 4'd4;
    localparam alu_op_t op_sll  = 4'd5;
    localparam alu_op_t op_srl  = 4'd6;
    localparam alu_op_t op_sra  = 4'd7;
    localparam alu_op_t op_slt  = 4'd8;
    localparam alu_op_t op_sltu = 4'd9;

    // ********************
    // branch conditions
    // ********************
    // same values as the funct3 field of the branch opcode
    localparam br_cond_t br_eq  = 3'd0;
    localparam br_cond_t br_ne  = 3'd1;
    localparam br_cond_t br_lt  = 3'd4;
    localparam br_cond_t br_ge  = 3'd5;
    localparam br_cond_t br_ltu = 3'd6;
    localparam br_cond_t br_geu = 3'd7;

endpackage

//--- alu/alu.sv
// ********************
// integer alu and branch compare
// ********************
`timescale 1ns/1ps

module alu (
    input  exu_pkg::alu_op_t  alu_op,
    input  logic              word_op,
    input  exu_pkg::br_cond_t br_cond,
    input  exu_pkg::xlen_t    op_a,
    input  exu_pkg::xlen_t    op_b,
    output exu_pkg::xlen_t    result,
    output logic              branch_taken
);
    import exu_pkg::*;

    xlen_t      in_a;
    xlen_t      in_b;
    xlen_t      srl_src;
    logic [5:0] shamt;
    xlen_t      raw;
    logic       br_eq_hit;
    logic       br_lt_hit;
    logic       br_ltu_hit;

    // word form works on sign-extended low halves
    assign in_a = word_op ? {{32{op_a[31]}}, op_a[31:0]} : op_a;
    assign in_b = word_op ? {{32{op_b[31]}}, op_b[31:0]} : op_b;

    // srlw shifts in zeros above bit 31
    assign srl_src = word_op ? {32'd0, in_a[31:0]} : in_a;
    assign shamt   = word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (alu_op)
            op_add:  raw = in_a + in_b;
            op_sub:  raw = in_a - in_b;
            op_and:  raw = in_a & in_b;
            op_or:   raw = in_a | in_b;
            op_xor:  raw = in_a ^ in_b;
            op_sll:  raw = in_a << shamt;
            op_srl:  raw = srl_src >> shamt;
            op_sra:  raw = xlen_t'($signed(in_a) >>> shamt);
            op_slt:  raw = {63'd0, $signed(in_a) < $signed(in_b)};
            op_sltu: raw = {63'd0, in_a < in_b};
            default: raw = '0;
        endcase
    end

    assign result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

    // ********************
    // branch condition
    // ********************
    // always on full 64-bit operands
    assign br_eq_hit  = (op_a == op_b);
    assign br_lt_hit  = ($signed(op_a) < $signed(op_b));
    assign br_ltu_hit = (op_a < op_b);

    always_comb begin
        case (br_cond)
            br_eq:   branch_taken = br_eq_hit;
            br_ne:   branch_taken = !br_eq_hit;
            br_lt:   branch_taken = br_lt_hit;
            br_ge:   branch_taken = !br_lt_hit;
            br_ltu:  branch_taken = br_ltu_hit;
            br_geu:  branch_taken = !br_ltu_hit;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- source/operand_forward.sv
// ********************
// operand forwarding and load-use hazard
// ********************
`timescale 1ns/1ps

module operand_forward (
    input  exu_pkg::reg_idx_t rs1,
    input  exu_pkg::reg_idx_t rs2,
    input  exu_pkg::xlen_t    reg_src1,
    input  exu_pkg::xlen_t    reg_src2,
    input  exu_pkg::xlen_t    imm_a,
    input  exu_pkg::xlen_t    imm_b,
    input  exu_pkg::xlen_t    jump_base_imm,
    input  logic              jump_jalr,
    input  logic              ex_valid,
    input  exu_pkg::reg_idx_t ex_rd,
    input  logic              ex_dest_wen,
    input  logic              ex_load_valid,
    input  exu_pkg::xlen_t    ex_result,
    input  logic              wb_valid,
    input  exu_pkg::reg_idx_t wb_rd,
    input  logic              wb_dest_wen,
    input  exu_pkg::xlen_t    wb_data,
    output exu_pkg::xlen_t    op_a,
    output exu_pkg::xlen_t    op_b,
    output exu_pkg::xlen_t    jump_base,
    output logic              hazard
);
    import exu_pkg::*;

    logic  ex_fwd_ok;
    logic  wb_fwd_ok;
    logic  rs1_ex_hit;
    logic  rs2_ex_hit;
    logic  rs1_wb_hit;
    logic  rs2_wb_hit;
    xlen_t src1;
    xlen_t src2;

    // a writer of x0 is never a forward source
    assign ex_fwd_ok = ex_valid && ex_dest_wen && (ex_rd != reg_zero);
    assign wb_fwd_ok = wb_valid && wb_dest_wen && (wb_rd != reg_zero);

    assign rs1_ex_hit = ex_fwd_ok && (rs1 == ex_rd);
    assign rs2_ex_hit = ex_fwd_ok && (rs2 == ex_rd);
    assign rs1_wb_hit = wb_fwd_ok && (rs1 == wb_rd);
    assign rs2_wb_hit = wb_fwd_ok && (rs2 == wb_rd);

    // younger result wins
    assign src1 = rs1_ex_hit ? ex_result : (rs1_wb_hit ? wb_data : reg_src1);
    assign src2 = rs2_ex_hit ? ex_result : (rs2_wb_hit ? wb_data : reg_src2);

    // jalr carries rs1 to the target adder, not to the alu
    assign op_a      = ((rs1 != reg_zero) && !jump_jalr) ? src1 : imm_a;
    assign op_b      = (rs2 != reg_zero) ? src2 : imm_b;
    assign jump_base = jump_jalr ? src1 : jump_base_imm;

    // load data not there yet
    assign hazard = ex_load_valid && (rs1_ex_hit || rs2_ex_hit);

endmodule

//--- source/redirect_ctrl.sv
// ********************
// jump target, next pc and redirect pulse
// ********************
`timescale 1ns/1ps

module redirect_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           decode_valid,
    input  logic           decode_ready,
    input  logic           jump_valid,
    input  logic           branch_valid,
    input  logic           branch_taken,
    input  logic           hazard,
    input  logic           ls_flush,
    input  exu_pkg::xlen_t next_pc,
    input  exu_pkg::xlen_t jump_base,
    input  exu_pkg::xlen_t jump_offset,
    output logic           jump_flag,
    output exu_pkg::xlen_t jump_addr,
    output exu_pkg::xlen_t sel_next_pc
);
    import exu_pkg::*;

    xlen_t target_sum;
    logic  redirect;
    logic  jump_once;

    assign target_sum = jump_base + jump_offset;
    assign jump_addr  = {target_sum[xlen-1:1], 1'b0};

    assign redirect    = jump_valid || (branch_valid && branch_taken);
    assign sel_next_pc = redirect ? jump_addr : next_pc;

    // one pulse per instruction, even if it waits in decode
    assign jump_flag = decode_valid && redirect && !hazard && !jump_once;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_once <= 1'b0;
        end else if (ls_flush) begin
            jump_once <= 1'b0;
        end else if (decode_valid && decode_ready) begin
            jump_once <= 1'b0;
        end else if (jump_flag) begin
            jump_once <= 1'b1;
        end
    end

    // fetch sees the redirect once
    assert property (@(posedge clk) disable iff (!rst_n)
        jump_flag && !(decode_valid && decode_ready) && !ls_flush |=> !jump_flag)
        else $error("jump_flag repeated without acceptance");

endmodule

//--- source/ex_ls_reg.sv
// ********************
// execute to load/store stage register
// ********************
`timescale 1ns/1ps

module ex_ls_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              decode_valid,
    input  logic              hazard,
    input  logic              ls_flush,
    input  logic              ls_ready,
    input  exu_pkg::xlen_t    pc,
    input  exu_pkg::xlen_t    sel_next_pc,
    input  exu_pkg::reg_idx_t rd,
    input  logic              dest_wen,
    input  logic              load_valid,
    input  exu_pkg::xlen_t    result,
    output logic              decode_ready,
    output logic              ex_valid,
    output exu_pkg::xlen_t    ex_pc,
    output exu_pkg::xlen_t    ex_next_pc,
    output exu_pkg::reg_idx_t ex_rd,
    output logic              ex_dest_wen,
    output logic              ex_load_valid,
    output exu_pkg::xlen_t    ex_result
);
    import exu_pkg::*;

    logic can_load;

    // empty, or the current one leaves this cycle
    assign can_load = !ex_valid || ls_ready;

    assign decode_ready = decode_valid && !hazard && !ls_flush && can_load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (ls_flush) begin
            ex_valid <= 1'b0;
        end else if (can_load) begin
            ex_valid <= decode_ready;
        end
    end

    // ********************
    // payload
    // ********************
    always_ff @(posedge clk) begin
        if (decode_ready) begin
            ex_pc         <= pc;
            ex_next_pc    <= sel_next_pc;
            ex_rd         <= rd;
            ex_dest_wen   <= dest_wen;
            ex_load_valid <= load_valid;
            ex_result     <= result;
        end
    end

    // held while load/store stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && !ls_ready && !ls_flush |=>
            ex_valid && $stable(ex_pc) && $stable(ex_next_pc) && $stable(ex_rd) &&
            $stable(ex_dest_wen) && $stable(ex_load_valid) && $stable(ex_result))
        else $error("stage register changed under back-pressure");

endmodule

//--- source/exu_top.sv
// ********************
// execute stage top level
// ********************
`timescale 1ns/1ps

module exu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              decode_valid,
    input  exu_pkg::reg_idx_t rs1,
    input  exu_pkg::reg_idx_t rs2,
    input  exu_pkg::reg_idx_t rd,
    input  logic              dest_wen,
    input  logic              load_valid,
    input  logic              jump_valid,
    input  logic              jump_jalr,
    input  logic              branch_valid,
    input  exu_pkg::alu_op_t  alu_op,
    input  logic              word_op,
    input  exu_pkg::br_cond_t br_cond,
    input  exu_pkg::xlen_t    pc,
    input  exu_pkg::xlen_t    next_pc,
    input  exu_pkg::xlen_t    imm_a,
    input  exu_pkg::xlen_t    imm_b,
    input  exu_pkg::xlen_t    jump_base_imm,
    input  exu_pkg::xlen_t    jump_offset,
    input  exu_pkg::xlen_t    reg_src1,
    input  exu_pkg::xlen_t    reg_src2,
    input  exu_pkg::xlen_t    wb_data,
    input  logic              ls_flush,
    input  logic              ls_ready,
    input  logic              wb_valid,
    input  exu_pkg::reg_idx_t wb_rd,
    input  logic              wb_dest_wen,
    output logic              decode_ready,
    output logic              ex_valid,
    output exu_pkg::xlen_t    ex_pc,
    output exu_pkg::xlen_t    ex_next_pc,
    output exu_pkg::xlen_t    ex_result,
    output exu_pkg::reg_idx_t ex_rd,
    output logic              ex_dest_wen,
    output logic              ex_load_valid,
    output logic              jump_flag,
    output exu_pkg::xlen_t    jump_addr
);
    import exu_pkg::*;

    xlen_t op_a;
    xlen_t op_b;
    xlen_t jump_base;
    xlen_t result;
    xlen_t sel_next_pc;
    logic  hazard;
    logic  branch_taken;

    operand_forward u_operand_forward (
        .rs1           (rs1),
        .rs2           (rs2),
        .reg_src1      (reg_src1),
        .reg_src2      (reg_src2),
        .imm_a         (imm_a),
        .imm_b         (imm_b),
        .jump_base_imm (jump_base_imm),
        .jump_jalr     (jump_jalr),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_dest_wen   (ex_dest_wen),
        .ex_load_valid (ex_load_valid),
        .ex_result     (ex_result),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_dest_wen   (wb_dest_wen),
        .wb_data       (wb_data),
        .op_a          (op_a),
        .op_b          (op_b),
        .jump_base     (jump_base),
        .hazard        (hazard)
    );

    alu u_alu (
        .alu_op       (alu_op),
        .word_op      (word_op),
        .br_cond      (br_cond),
        .op_a         (op_a),
        .op_b         (op_b),
        .result       (result),
        .branch_taken (branch_taken)
    );

    redirect_ctrl u_redirect_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .jump_valid   (jump_valid),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .hazard       (hazard),
        .ls_flush     (ls_flush),
        .next_pc      (next_pc),
        .jump_base    (jump_base),
        .jump_offset  (jump_offset),
        .jump_flag    (jump_flag),
        .jump_addr    (jump_addr),
        .sel_next_pc  (sel_next_pc)
    );

    ex_ls_reg u_ex_ls_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .decode_valid  (decode_valid),
        .hazard        (hazard),
        .ls_flush      (ls_flush),
        .ls_ready      (ls_ready),
        .pc            (pc),
        .sel_next_pc   (sel_next_pc),
        .rd            (rd),
        .dest_wen      (dest_wen),
        .load_valid    (load_valid),
        .result        (result),
        .decode_ready  (decode_ready),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_next_pc    (ex_next_pc),
        .ex_rd         (ex_rd),
        .ex_dest_wen   (ex_dest_wen),
        .ex_load_valid (ex_load_valid),
        .ex_result     (ex_result)
    );

endmodule

//--- test/tb_clock.sv
// ********************
// testbench clock and reset
// ********************
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // two full cycles in reset, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- test/tb_exu.sv
// ********************
// execute stage testbench, one case per line of the case file
// ********************
`timescale 1ns/1ps

module tb_exu;
    import exu_pkg::*;

    localparam int period  = 100;
    localparam int n_field = 23;

    logic     clk;
    logic     rst_n;
    logic     decode_valid  = 1'b0;
    reg_idx_t rs1           = '0;
    reg_idx_t rs2           = '0;
    reg_idx_t rd            = '0;
    logic     dest_wen      = 1'b0;
    logic     load_valid    = 1'b0;
    logic     jump_valid    = 1'b0;
    logic     jump_jalr     = 1'b0;
    logic     branch_valid  = 1'b0;
    alu_op_t  alu_op        = '0;
    logic     word_op       = 1'b0;
    br_cond_t br_cond       = '0;
    xlen_t    pc            = '0;
    xlen_t    next_pc       = '0;
    xlen_t    imm_a         = '0;
    xlen_t    imm_b         = '0;
    xlen_t    jump_base_imm = '0;
    xlen_t    jump_offset   = '0;
    xlen_t    reg_src1      = '0;
    xlen_t    reg_src2      = '0;
    xlen_t    wb_data       = '0;
    logic     ls_flush      = 1'b0;
    logic     ls_ready      = 1'b0;
    logic     wb_valid      = 1'b0;
    reg_idx_t wb_rd         = '0;
    logic     wb_dest_wen   = 1'b0;
    logic     decode_ready;
    logic     ex_valid;
    logic     ex_dest_wen;
    logic     ex_load_valid;
    logic     jump_flag;
    xlen_t    ex_pc;
    xlen_t    ex_next_pc;
    xlen_t    ex_result;
    xlen_t    jump_addr;
    reg_idx_t ex_rd;

    // fields the stage register took on the last acceptance
    xlen_t    held_pc  = '0;
    reg_idx_t held_rd  = '0;
    logic     held_wen = 1'b0;
    logic     held_ld  = 1'b0;

    string    cases[$];
    logic     cases_loaded = 1'b0;
    int       checks = 0;
    int       errors = 0;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    exu_top u_dut (.*);

    function automatic logic [63:0] random_word();
        return {$urandom, $urandom};
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic load_cases();
        int    fd;
        string line;
        fd = $fopen("test/exu_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the case file test/exu_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cases.push_back(line);
                end
            end
            $fclose(fd);
            if (cases.size() == 0) begin
                errors++;
                $display("the case file holds no cases");
            end
        end
    endtask

    // drive on the falling edge, combinational checks mid low phase,
    // stage register checks just after the rising edge
    task automatic run_case(input string line, input int idx);
        int          n;
        int          kind;
        logic [3:0]  op;
        logic        w;
        logic [2:0]  cond;
        logic [7:0]  flg;
        logic [4:0]  s1;
        logic [4:0]  s2;
        logic [4:0]  d;
        logic [4:0]  wrd;
        logic [63:0] src1;
        logic [63:0] src2;
        logic [63:0] ia;
        logic [63:0] ib;
        logic [63:0] jo;
        logic [63:0] pca;
        logic [63:0] npc;
        logic [63:0] wd;
        logic        e_ready;
        logic        e_jump;
        logic        e_valid;
        logic [63:0] e_jaddr;
        logic [63:0] e_result;
        logic [63:0] e_next;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    kind, op, w, cond, flg, s1, s2, d, src1, src2, ia, ib, jo, pca, npc,
                    wrd, wd, e_ready, e_jump, e_jaddr, e_valid, e_result, e_next);
        if (n != n_field) begin
            errors++;
            $display("case %0d: only %0d of %0d fields could be read", idx, n, n_field);
        end else begin
            @(negedge clk);
            decode_valid  = (kind != 0);
            alu_op        = op;
            word_op       = w;
            br_cond       = cond;
            dest_wen      = flg[0];
            load_valid    = flg[1];
            jump_valid    = flg[2];
            jump_jalr     = flg[3];
            branch_valid  = flg[4];
            wb_valid      = flg[5];
            ls_ready      = flg[6];
            ls_flush      = flg[7];
            rs1           = s1;
            rs2           = s2;
            rd            = d;
            pc            = pca;
            next_pc       = npc;
            imm_a         = ia;
            imm_b         = ib;
            jump_base_imm = pca;
            jump_offset   = jo;
            // register file values that cannot reach the result get noise
            reg_src1      = (s1 == reg_zero && !flg[3]) ? random_word() : src1;
            reg_src2      = (s2 == reg_zero) ? random_word() : src2;
            wb_dest_wen   = 1'b1;
            wb_rd         = flg[5] ? wrd : reg_idx_t'($urandom);
            wb_data       = flg[5] ? wd : random_word();
            if (e_ready) begin
                held_pc  = pca;
                held_rd  = d;
                held_wen = flg[0];
                held_ld  = flg[1];
            end
            #(period / 4);
            check_value(64'(decode_ready), 64'(e_ready), $sformatf("case %0d decode_ready", idx));
            check_value(64'(jump_flag), 64'(e_jump), $sformatf("case %0d jump_flag", idx));
            if (e_jump) begin
                check_value(jump_addr, e_jaddr, $sformatf("case %0d jump_addr", idx));
            end
            @(posedge clk);
            #1;
            check_value(64'(ex_valid), 64'(e_valid), $sformatf("case %0d ex_valid", idx));
            if (e_valid) begin
                check_value(ex_result, e_result, $sformatf("case %0d ex_result", idx));
                check_value(ex_next_pc, e_next, $sformatf("case %0d ex_next_pc", idx));
                check_value(ex_pc, held_pc, $sformatf("case %0d ex_pc", idx));
                check_value(64'(ex_rd), 64'(held_rd), $sformatf("case %0d ex_rd", idx));
                check_value(64'(ex_dest_wen), 64'(held_wen),
                            $sformatf("case %0d ex_dest_wen", idx));
                check_value(64'(ex_load_valid), 64'(held_ld),
                            $sformatf("case %0d ex_load_valid", idx));
            end
        end
    endtask

    initial begin
        void'($urandom(32'he398_c022));
        load_cases();
        cases_loaded = 1'b1;
        wait (rst_n === 1'b1);
        foreach (cases[i]) begin
            run_case(cases[i], i);
        end
        $display("%0d cases, %0d checks, %0d errors", cases.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // ********************
    // watchdog
    // ********************
    initial begin
        wait (cases_loaded);
        #((cases.size() + 5) * 20 * period);
        $display("watchdog expired, the cases did not finish in time");
        $display("Test failures found");
        $finish;
    end

endmodule

//--- test/exu_cases.txt
# in: kind op word cond flags rs1 rs2 rd src1 src2 imm_a imm_b j_off pc npc wb_rd wb_data
# exp: ready jump j_addr valid result ex_npc; flags wen,ld,jmp,jalr,br,wb,ls_rdy,flush bit 0 up
1 0 0 0 41 01 02 0a 7fffffff 1 0 0 0 100 104 0 0 1 0 0 1 80000000 104
1 1 0 0 41 01 02 0a 5 7 0 0 0 100 104 0 0 1 0 0 1 fffffffffffffffe 104
1 2 0 0 41 01 02 0a ff00 f0f 0 0 0 100 104 0 0 1 0 0 1 f00 104
1 3 0 0 41 01 02 0a ff00 f0f 0 0 0 100 104 0 0 1 0 0 1 ff0f 104
1 4 0 0 41 01 02 0a ff00 f0f 0 0 0 100 104 0 0 1 0 0 1 f00f 104
1 5 0 0 41 01 02 0a 1 3f 0 0 0 100 104 0 0 1 0 0 1 8000000000000000 104
1 6 0 0 41 01 02 0a 8000000000000000 4 0 0 0 100 104 0 0 1 0 0 1 0800000000000000 104
1 7 0 0 41 01 02 0a 8000000000000000 4 0 0 0 100 104 0 0 1 0 0 1 f800000000000000 104
1 8 0 0 41 01 02 0a ffffffffffffffff 1 0 0 0 100 104 0 0 1 0 0 1 1 104
1 9 0 0 41 01 02 0a ffffffffffffffff 1 0 0 0 100 104 0 0 1 0 0 1 0 104
1 0 1 0 41 01 02 0a 7fffffff 1 0 0 0 100 104 0 0 1 0 0 1 ffffffff80000000 104
1 1 1 0 41 01 02 0a 100000000 1 0 0 0 100 104 0 0 1 0 0 1 ffffffffffffffff 104
1 5 1 0 41 01 02 0a 1 3f 0 0 0 100 104 0 0 1 0 0 1 ffffffff80000000 104
1 6 1 0 41 01 02 0a 80000000 4 0 0 0 100 104 0 0 1 0 0 1 8000000 104
1 7 1 0 41 01 02 0a 80000000 4 0 0 0 100 104 0 0 1 0 0 1 fffffffff8000000 104
1 8 1 0 41 01 02 0a 80000000 1 0 0 0 100 104 0 0 1 0 0 1 1 104
1 0 0 0 41 01 02 0a 1000 0 0 0 0 100 104 0 0 1 0 0 1 1000 104
1 0 0 0 61 0a 02 0b 111 5 0 0 0 100 104 0a dead 1 0 0 1 1005 104
1 0 0 0 61 01 0c 0d 20 999 0 0 0 100 104 0c 7 1 0 0 1 27 104
1 0 0 0 61 00 00 00 0 0 30 4 0 100 104 00 dead 1 0 0 1 34 104
1 0 0 0 6d 00 00 01 200 0 300 4 11 300 304 00 dead 1 1 210 1 304 210
1 0 0 0 50 03 04 00 5 5 0 0 20 400 404 0 0 1 1 420 1 a 420
1 0 0 1 50 03 04 00 5 5 0 0 20 500 504 0 0 1 0 0 1 a 504
1 0 0 4 50 03 04 00 ffffffffffffffff 1 0 0 8 600 604 0 0 1 1 608 1 0 608
1 0 0 5 50 03 04 00 1 ffffffffffffffff 0 0 fffffffffffffff0 800 804 0 0 1 1 7f0 1 0 7f0
1 0 0 0 45 00 00 0f 0 0 900 4 7 900 904 0 0 1 1 906 1 904 906
1 0 0 0 05 00 00 0f 0 0 a00 4 10 a00 a04 0 0 0 1 a10 1 904 906
1 0 0 0 05 00 00 0f 0 0 a00 4 10 a00 a04 0 0 0 0 0 1 904 906
1 0 0 0 45 00 00 0f 0 0 a00 4 10 a00 a04 0 0 1 0 0 1 a04 a10
1 0 0 0 43 01 00 05 1000 0 0 8 0 b00 b04 0 0 1 0 0 1 1008 b04
1 0 0 0 10 05 02 00 9 9 0 0 40 c00 c04 0 0 0 0 0 1 1008 b04
1 0 0 0 50 05 02 00 9 9 0 0 40 c00 c04 0 0 0 0 0 0 0 0
1 0 0 0 50 05 02 00 9 9 0 0 40 c00 c04 0 0 1 1 c40 1 12 c40
1 0 0 0 c1 01 02 07 1 1 0 0 0 100 104 0 0 0 0 0 0 0 0
1 0 0 0 41 01 02 07 1 2 0 0 0 100 104 0 0 1 0 0 1 3 104
1 0 0 0 05 00 00 0f 0 0 d00 4 30 d00 d04 0 0 0 1 d30 1 3 104
1 0 0 0 85 00 00 0f 0 0 d00 4 30 d00 d04 0 0 0 0 0 0 0 0
1 0 0 0 45 00 00 0f 0 0 d00 4 30 d00 d04 0 0 1 1 d30 1 d04 d30
0 0 0 0 40 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- all.f
common/exu_pkg.sv
alu/alu.sv
source/operand_forward.sv
source/redirect_ctrl.sv
source/ex_ls_reg.sv
source/exu_top.sv
test/tb_clock.sv
test/tb_exu.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= Test failures found

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
